/* verilog/cache_geom_pkg.sv */
// cache geometry shared by every block: address and data widths, line layout
// and the tree-PLRU walk used by the replacement unit.
// word and line types are used by the bus structs and by the datapath
package cache_geom_pkg;

  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int LINE_BYTES     = 16;
  localparam int OFFSET_W       = $clog2(LINE_BYTES);  // byte offset inside a line
  localparam int WORDS_PER_LINE = 4;

  localparam int MAX_WAYS  = 16;  // widest tree the helpers can walk
  localparam int MAX_DEPTH = $clog2(MAX_WAYS);

  typedef logic [WORD_W-1:0]                word_t;
  typedef logic [WORDS_PER_LINE*WORD_W-1:0] line_t;
  typedef logic [MAX_WAYS-2:0]              plru_tree_t;  // caller pads its NUM_WAYS-1 bits

  // follow the node bits from the root, 0 goes left and 1 goes right
  function automatic int plru_victim(plru_tree_t tree, int num_ways);
    int   node;
    int   way;
    logic dir;
    node = 0;
    way  = 0;
    for (int lvl = 0; lvl < MAX_DEPTH; lvl++) begin
      if ((1 << lvl) < num_ways) begin
        dir  = tree[node];
        way  = (way << 1) | int'(dir);
        node = 2 * node + 1 + int'(dir);
      end
    end
    return way;
  endfunction

  // point each node on the path to way away from it
  function automatic plru_tree_t plru_touch(plru_tree_t tree, int way, int num_ways);
    plru_tree_t nxt;
    int         depth;
    int         node;
    logic       b;
    nxt   = tree;
    depth = 0;
    node  = 0;
    for (int i = 0; i < MAX_DEPTH; i++) begin
      if ((1 << i) < num_ways) depth++;
    end
    for (int lvl = 0; lvl < MAX_DEPTH; lvl++) begin
      if (lvl < depth) begin
        b         = 1'((way >> (depth - 1 - lvl)) & 1);  // msb of way picks the root branch
        nxt[node] = ~b;
        node      = 2 * node + 1 + int'(b);
      end
    end
    return nxt;
  endfunction

endpackage

/* verilog/cache_bus_pkg.sv */
// payload structs for the four valid/ready channels of the cache.
// the higher side moves single words, the lower side whole lines
package cache_bus_pkg;

  // word request from the requester, a write carries no response
  typedef struct packed {
    logic [cache_geom_pkg::ADDR_W-1:0] addr;
    logic                              we;
    cache_geom_pkg::word_t             wdata;
  } hc_req_t;  // 65 bits

  // read answer, echoes the request address
  typedef struct packed {
    logic [cache_geom_pkg::ADDR_W-1:0] addr;
    cache_geom_pkg::word_t             rdata;
  } hc_resp_t;  // 64 bits

  // line read or write-back toward memory
  typedef struct packed {
    logic [cache_geom_pkg::ADDR_W-1:0] addr;  // always line aligned
    logic                              we;    // 1 = write-back of a dirty victim
    cache_geom_pkg::line_t             line;  // only meaningful when we is set
  } lc_req_t;  // 161 bits

  // fill returned for our own line read
  typedef struct packed {
    logic [cache_geom_pkg::ADDR_W-1:0] addr;
    cache_geom_pkg::line_t             line;
  } lc_fill_t;  // 160 bits

endpackage

/* verilog/cache_way_ram.sv */
// storage for one payload across all ways, NUM_SETS entries per way.
// one way is written per clock, all ways of the addressed set read back
// combinationally. used for the tag array and for the line data
`timescale 1ns/1ps

module cache_way_ram #(
  parameter int  NUM_WAYS = 4,
  parameter int  NUM_SETS = 16,
  parameter type entry_t  = logic [31:0],
  localparam int WAY_W    = $clog2(NUM_WAYS),
  localparam int SET_W    = $clog2(NUM_SETS)
) (
  input  logic             clk_in,
  input  logic [SET_W-1:0] set_idx,
  input  logic             we,
  input  logic [WAY_W-1:0] way,
  input  entry_t           wdata,
  output entry_t           rdata_all [NUM_WAYS]  // every way of set_idx
);

  entry_t mem [NUM_WAYS][NUM_SETS];  // contents undefined until written

  always_ff @(posedge clk_in) begin
    if (we) mem[way][set_idx] <= wdata;
  end

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      rdata_all[w] = mem[w][set_idx];
    end
  end

endmodule

/* verilog/cache_tag_store.sv */
// tag side of the cache: tag array, valid and dirty bits, hit compare
// and the state of the way picked for replacement.
// valid/dirty sit in flops so reset and flush clear every line at once
`timescale 1ns/1ps

module cache_tag_store #(
  parameter int  NUM_WAYS = 4,
  parameter int  NUM_SETS = 16,
  localparam int WAY_W    = $clog2(NUM_WAYS),
  localparam int SET_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = cache_geom_pkg::ADDR_W - SET_W - cache_geom_pkg::OFFSET_W
) (
  input  logic             clk_in,
  input  logic             rst_N_in,
  input  logic [SET_W-1:0] set_idx,
  input  logic [TAG_W-1:0] cur_tag,
  input  logic             tag_we,       // install or dirty update
  input  logic [WAY_W-1:0] wr_way,
  input  logic             new_dirty,
  input  logic             clear_all,    // flush
  input  logic [WAY_W-1:0] victim_way,
  output logic             hit,
  output logic [WAY_W-1:0] hit_way,
  output logic             victim_dirty,
  output logic [TAG_W-1:0] victim_tag
);

  typedef logic [TAG_W-1:0] tag_entry_t;

  tag_entry_t          tags    [NUM_WAYS];  // tags of the current set
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];

  // tag is rewritten on every tag_we, same value on a write hit
  cache_way_ram #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS),
    .entry_t  (tag_entry_t)
  ) u_tag_ram (
    .clk_in    (clk_in),
    .set_idx   (set_idx),
    .we        (tag_we),
    .way       (wr_way),
    .wdata     (cur_tag),
    .rdata_all (tags)
  );

  always_ff @(posedge clk_in) begin
    if (!rst_N_in || clear_all) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;  // dirty lines are dropped, not written back
      end
    end else if (tag_we) begin
      valid_q[set_idx][wr_way] <= 1'b1;
      dirty_q[set_idx][wr_way] <= new_dirty;
    end
  end

  // at most one way can match, a tag is never installed twice in a set
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (valid_q[set_idx][w] && (tags[w] == cur_tag)) begin
        hit     = 1'b1;
        hit_way = WAY_W'(w);
      end
    end
  end

  // dirty implies valid, masked anyway for the cleared case
  assign victim_dirty = valid_q[set_idx][victim_way] & dirty_q[set_idx][victim_way];
  assign victim_tag   = tags[victim_way];

endmodule

/* verilog/cache_plru.sv */
// tree pseudo-LRU replacement, one NUM_WAYS-1 bit tree per set.
// victim_way follows the tree of set_idx, a touch flips the path
// away from touch_way on the next edge
`timescale 1ns/1ps

module cache_plru #(
  parameter int  NUM_WAYS = 4,
  parameter int  NUM_SETS = 16,
  localparam int WAY_W    = $clog2(NUM_WAYS),
  localparam int SET_W    = $clog2(NUM_SETS),
  localparam int TREE_W   = NUM_WAYS - 1
) (
  input  logic             clk_in,
  input  logic             rst_N_in,
  input  logic [SET_W-1:0] set_idx,
  input  logic             touch,
  input  logic [WAY_W-1:0] touch_way,
  output logic [WAY_W-1:0] victim_way
);

  logic [TREE_W-1:0]          tree_q [NUM_SETS];
  cache_geom_pkg::plru_tree_t cur_tree;   // tree of set_idx padded to helper width
  cache_geom_pkg::plru_tree_t next_tree;

  always_comb begin
    cur_tree             = '0;
    cur_tree[TREE_W-1:0] = tree_q[set_idx];
  end

  assign victim_way = WAY_W'(cache_geom_pkg::plru_victim(cur_tree, NUM_WAYS));
  assign next_tree  = cache_geom_pkg::plru_touch(cur_tree, int'(touch_way), NUM_WAYS);

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        tree_q[s] <= '0;  // all trees point at way 0
      end
    end else if (touch) begin
      tree_q[set_idx] <= next_tree[TREE_W-1:0];
    end
  end

endmodule

/* verilog/cache_ctrl.sv */
// control FSM of the blocking write-back cache.
// registers one request, looks it up, and on a miss writes back a dirty
// victim, reads the line and installs it. hits and fills both pass
// through the install state, which merges a write word and touches PLRU
`timescale 1ns/1ps

module cache_ctrl #(
  parameter int  NUM_WAYS = 4,
  parameter int  NUM_SETS = 16,
  localparam int WAY_W    = $clog2(NUM_WAYS),
  localparam int SET_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = cache_geom_pkg::ADDR_W - SET_W - cache_geom_pkg::OFFSET_W
) (
  input  logic                    clk_in,
  input  logic                    rst_N_in,
  input  logic                    flush,
  // higher side
  input  logic                    hc_req_valid,
  output logic                    hc_req_ready,
  input  cache_bus_pkg::hc_req_t  hc_req,
  output logic                    hc_resp_valid,
  input  logic                    hc_resp_ready,
  output cache_bus_pkg::hc_resp_t hc_resp,
  // lower side
  output logic                    lc_req_valid,
  input  logic                    lc_req_ready,
  output cache_bus_pkg::lc_req_t  lc_req,
  input  logic                    lc_fill_valid,
  output logic                    lc_fill_ready,
  input  cache_bus_pkg::lc_fill_t lc_fill,
  // tag store
  output logic [SET_W-1:0]        set_idx,
  output logic [TAG_W-1:0]        cur_tag,
  input  logic                    hit,
  input  logic [WAY_W-1:0]        hit_way,
  input  logic                    victim_dirty,
  input  logic [TAG_W-1:0]        victim_tag,
  input  logic [WAY_W-1:0]        victim_way,
  output logic                    tag_we,
  output logic [WAY_W-1:0]        wr_way,
  output logic                    new_dirty,
  output logic                    clear_all,
  // data store
  output logic                    data_we,
  output cache_geom_pkg::line_t   data_wdata,
  input  cache_geom_pkg::line_t   data_rdata [NUM_WAYS],
  // replacement
  output logic                    plru_touch,
  output logic [WAY_W-1:0]        touch_way
);

  localparam int WSEL_W = $clog2(cache_geom_pkg::WORDS_PER_LINE);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_WRITEBACK,  // dirty victim out first
    S_FETCH,      // line read request
    S_FILL_WAIT,
    S_INSTALL,    // store update, shared by hit and fill
    S_RESPOND,
    S_FLUSH
  } state_t;

  state_t                  state_q, state_d;
  logic                    miss_q;     // install comes from a fill
  cache_bus_pkg::hc_req_t  req_q;      // request being served
  cache_geom_pkg::line_t   line_q;     // hit line, victim line or fill line
  logic [WAY_W-1:0]        way_q;      // way being worked on
  logic [TAG_W-1:0]        wb_tag_q;   // victim tag for the write-back address
  logic [WAY_W-1:0]        sel_way;
  logic [WSEL_W-1:0]       word_sel;
  cache_geom_pkg::word_t   cur_word;
  cache_geom_pkg::line_t   merged_line;

  // address split: tag | set | word | byte
  assign cur_tag  = req_q.addr[cache_geom_pkg::ADDR_W-1 -: TAG_W];
  assign set_idx  = req_q.addr[cache_geom_pkg::OFFSET_W +: SET_W];
  assign word_sel = req_q.addr[cache_geom_pkg::OFFSET_W-1 -: WSEL_W];

  assign sel_way  = hit ? hit_way : victim_way;
  assign cur_word = line_q[word_sel*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W];

  always_comb begin
    merged_line = line_q;
    if (req_q.we) begin
      merged_line[word_sel*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W] = req_q.wdata;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      S_IDLE: begin
        if (flush) state_d = S_FLUSH;  // flush wins over a request
        else if (hc_req_valid) state_d = S_LOOKUP;
      end
      S_LOOKUP: begin
        if (hit) state_d = S_INSTALL;
        else if (victim_dirty) state_d = S_WRITEBACK;
        else state_d = S_FETCH;
      end
      S_WRITEBACK: if (lc_req_ready) state_d = S_FETCH;
      S_FETCH:     if (lc_req_ready) state_d = S_FILL_WAIT;
      S_FILL_WAIT: if (lc_fill_valid) state_d = S_INSTALL;
      S_INSTALL:   state_d = req_q.we ? S_IDLE : S_RESPOND;  // writes get no response
      S_RESPOND:   if (hc_resp_ready) state_d = S_IDLE;
      S_FLUSH:     state_d = S_IDLE;
      default:     state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q <= S_IDLE;
      miss_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == S_LOOKUP) miss_q <= !hit;
    end
  end

  always_ff @(posedge clk_in) begin
    if (state_q == S_IDLE && !flush && hc_req_valid) req_q <= hc_req;
    if (state_q == S_LOOKUP) begin
      way_q    <= sel_way;
      line_q   <= data_rdata[sel_way];  // victim line kept for the write-back
      wb_tag_q <= victim_tag;
    end
    if (state_q == S_FILL_WAIT && lc_fill_valid) line_q <= lc_fill.line;
  end

  assign hc_req_ready  = (state_q == S_IDLE);
  assign hc_resp_valid = (state_q == S_RESPOND);
  assign lc_fill_ready = (state_q == S_FILL_WAIT);
  assign lc_req_valid  = (state_q == S_WRITEBACK) || (state_q == S_FETCH);

  always_comb begin
    hc_resp.addr  = req_q.addr;
    hc_resp.rdata = cur_word;  // line_q holds still while waiting
  end

  always_comb begin
    lc_req.we = (state_q == S_WRITEBACK);
    if (state_q == S_WRITEBACK) begin
      lc_req.addr = {wb_tag_q, set_idx, {cache_geom_pkg::OFFSET_W{1'b0}}};
      lc_req.line = line_q;
    end else begin
      lc_req.addr = {cur_tag, set_idx, {cache_geom_pkg::OFFSET_W{1'b0}}};
      lc_req.line = '0;
    end
  end

  // a read hit only touches, writes and fills also update the stores
  assign tag_we     = (state_q == S_INSTALL) && (miss_q || req_q.we);
  assign data_we    = tag_we;
  assign wr_way     = way_q;
  assign new_dirty  = req_q.we;  // fill of a read comes in clean
  assign data_wdata = merged_line;
  assign clear_all  = (state_q == S_FLUSH);
  assign plru_touch = (state_q == S_INSTALL);
  assign touch_way  = way_q;

endmodule

/* verilog/cache_top.sv */
// set-associative write-back cache between a word requester and a line memory.
// NUM_WAYS and NUM_SETS are set here and handed to every block below.
// all four channels are valid/ready, flush is sampled while hc_req_ready is high
`timescale 1ns/1ps

module cache_top #(
  parameter int  NUM_WAYS = 4,
  parameter int  NUM_SETS = 16,
  localparam int WAY_W    = $clog2(NUM_WAYS),
  localparam int SET_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = cache_geom_pkg::ADDR_W - SET_W - cache_geom_pkg::OFFSET_W
) (
  input  logic                    clk_in,
  input  logic                    rst_N_in,
  input  logic                    flush,
  input  logic                    hc_req_valid,
  output logic                    hc_req_ready,
  input  cache_bus_pkg::hc_req_t  hc_req,
  output logic                    hc_resp_valid,
  input  logic                    hc_resp_ready,
  output cache_bus_pkg::hc_resp_t hc_resp,
  output logic                    lc_req_valid,
  input  logic                    lc_req_ready,
  output cache_bus_pkg::lc_req_t  lc_req,
  input  logic                    lc_fill_valid,
  output logic                    lc_fill_ready,
  input  cache_bus_pkg::lc_fill_t lc_fill
);

  logic [SET_W-1:0]      set_idx;
  logic [TAG_W-1:0]      cur_tag;
  logic                  hit, victim_dirty;
  logic [WAY_W-1:0]      hit_way, victim_way;
  logic [TAG_W-1:0]      victim_tag;
  logic                  tag_we, new_dirty, clear_all, data_we;
  logic [WAY_W-1:0]      wr_way;                  // same way for tag and data writes
  cache_geom_pkg::line_t data_wdata;
  cache_geom_pkg::line_t data_rdata [NUM_WAYS];
  logic                  plru_touch;
  logic [WAY_W-1:0]      touch_way;

  cache_ctrl #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) u_ctrl (
    .clk_in, .rst_N_in, .flush,
    .hc_req_valid, .hc_req_ready, .hc_req,
    .hc_resp_valid, .hc_resp_ready, .hc_resp,
    .lc_req_valid, .lc_req_ready, .lc_req,
    .lc_fill_valid, .lc_fill_ready, .lc_fill,
    .set_idx, .cur_tag, .hit, .hit_way, .victim_dirty, .victim_tag, .victim_way,
    .tag_we, .wr_way, .new_dirty, .clear_all,
    .data_we, .data_wdata, .data_rdata,
    .plru_touch, .touch_way
  );

  cache_tag_store #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) u_tag_store (
    .clk_in, .rst_N_in, .set_idx, .cur_tag,
    .tag_we, .wr_way, .new_dirty, .clear_all, .victim_way,
    .hit, .hit_way, .victim_dirty, .victim_tag
  );

  cache_plru #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) u_plru (
    .clk_in, .rst_N_in, .set_idx,
    .touch(plru_touch), .touch_way, .victim_way
  );

  // line data store for all ways of every set
  cache_way_ram #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS),
    .entry_t  (cache_geom_pkg::line_t)
  ) u_data_ram (
    .clk_in, .set_idx, .we(data_we), .way(wr_way),
    .wdata(data_wdata), .rdata_all(data_rdata)
  );

endmodule

/* testbench/tb_cache_tasks.svh */
// tasks of the cache testbench, included inside the testbench module.
// handshake helpers with bounded waits, address helpers for the memory
// model, and one task per directed test
`ifndef TB_CACHE_TASKS_SVH
`define TB_CACHE_TASKS_SVH

localparam logic [31:0]           ADDR_X  = 32'h0000_0024;  // set 2, word 1
localparam cache_geom_pkg::word_t WDATA_X = 32'h5a5a_0324;
localparam cache_geom_pkg::word_t WDATA_A = 32'h0a0a_c3c3;

// set 5 with tags 0..4, word 2 of each line
function automatic logic [31:0] evict_addr(input int i);
  return 32'h0000_0058 + 32'(i) * 32'h0000_0100;
endfunction

function automatic logic [31:0] line_addr(input logic [31:0] a);
  return {a[cache_geom_pkg::ADDR_W-1:cache_geom_pkg::OFFSET_W],
          {cache_geom_pkg::OFFSET_W{1'b0}}};
endfunction

function automatic int line_idx(input logic [31:0] a);
  return int'(a[cache_geom_pkg::OFFSET_W +: MEM_IDX_W]);
endfunction

function automatic int word_idx(input logic [31:0] a);
  return int'(a[cache_geom_pkg::OFFSET_W-1:2]);  // byte offset over 4
endfunction

function automatic cache_geom_pkg::word_t word_of(input cache_geom_pkg::line_t l,
                                                  input logic [31:0] a);
  return l[word_idx(a)*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W];
endfunction

function automatic cache_geom_pkg::line_t with_word(input cache_geom_pkg::line_t l,
                                                    input logic [31:0] a,
                                                    input cache_geom_pkg::word_t w);
  cache_geom_pkg::line_t r;
  r = l;
  r[word_idx(a)*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W] = w;
  return r;
endfunction

task automatic next_cycle();
  @(posedge clk_in);
  #1;  // inputs change just after the edge
endtask

task automatic compare_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
  if (got !== exp) begin
    stop_failed($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", what, got, exp));
  end
endtask

task automatic wait_ready(output int cycles);
  cycles = 0;
  while (hc_req_ready !== 1'b1) begin
    next_cycle();
    cycles++;
    if (cycles > TIMEOUT_CYCLES) stop_failed("cache never became ready for a request");
  end
endtask

task automatic send_req(input logic [31:0] addr, input logic we,
                        input cache_geom_pkg::word_t wdata);
  int lat;
  hc_req_valid = 1'b1;
  hc_req.addr  = addr;
  hc_req.we    = we;
  hc_req.wdata = wdata;
  wait_ready(lat);
  next_cycle();  // transfer edge
  hc_req_valid = 1'b0;
endtask

task automatic wait_resp(output int cycles, output cache_bus_pkg::hc_resp_t resp);
  cycles = 0;
  while (hc_resp_valid !== 1'b1) begin
    next_cycle();
    cycles++;
    if (cycles > TIMEOUT_CYCLES) stop_failed("no read response from the cache in time");
  end
  resp = hc_resp;
endtask

// lat counts cycles from the request transfer to hc_resp_valid
task automatic read_word(input logic [31:0] addr, output cache_geom_pkg::word_t data,
                         output int lat);
  cache_bus_pkg::hc_resp_t resp;
  send_req(addr, 1'b0, '0);
  wait_resp(lat, resp);
  compare_value("hc_resp.addr", 128'(resp.addr), 128'(addr));
  data = resp.rdata;
  next_cycle();  // hc_resp_ready is high, response taken here
endtask

task automatic write_word(input logic [31:0] addr, input cache_geom_pkg::word_t wdata,
                          output int lat);
  send_req(addr, 1'b1, wdata);
  wait_ready(lat);  // a write ends when the cache takes requests again
endtask

task automatic read_miss_fills_line();
  int                    n0;
  int                    lat;
  cache_geom_pkg::word_t got;
  n0 = req_log.size();
  read_word(ADDR_X, got, lat);
  compare_value("lower request count", 128'(req_log.size() - n0), 128'(1));
  compare_value("lc_req.we", 128'(req_log[n0].we), 128'(0));
  compare_value("lc_req.addr", 128'(req_log[n0].addr), 128'(line_addr(ADDR_X)));
  compare_value("hc_resp.rdata", 128'(got), 128'(word_of(mem[line_idx(ADDR_X)], ADDR_X)));
endtask

task automatic read_hit_no_lower();
  int                    n0;
  int                    lat;
  logic [31:0]           addr;
  cache_geom_pkg::word_t got;
  addr = line_addr(ADDR_X) + 32'hc;  // last word of the cached line
  n0   = req_log.size();
  read_word(addr, got, lat);
  compare_value("lower request count", 128'(req_log.size() - n0), 128'(0));
  compare_value("hc_resp_valid latency", 128'(lat), 128'(2));
  compare_value("hc_resp.rdata", 128'(got), 128'(word_of(mem[line_idx(addr)], addr)));
endtask

task automatic write_hit_merges();
  int                    n0;
  int                    lat;
  logic [31:0]           addr;
  cache_geom_pkg::word_t got;
  cache_geom_pkg::line_t exp_line;
  n0 = req_log.size();
  write_word(ADDR_X, WDATA_X, lat);
  compare_value("hc_req_ready latency", 128'(lat), 128'(2));
  exp_line = with_word(mem[line_idx(ADDR_X)], ADDR_X, WDATA_X);
  for (int w = 0; w < cache_geom_pkg::WORDS_PER_LINE; w++) begin
    addr = line_addr(ADDR_X) + 32'(4 * w);
    read_word(addr, got, lat);
    compare_value("hc_resp.rdata", 128'(got), 128'(word_of(exp_line, addr)));
  end
  compare_value("lower request count", 128'(req_log.size() - n0), 128'(0));
endtask

// ways fill as 0, 2, 1, 3 and the tree then points back at way 0
task automatic dirty_victim_written_back();
  int                    n0;
  int                    lat;
  cache_geom_pkg::word_t got;
  cache_geom_pkg::line_t exp_a;
  exp_a = with_word(mem[line_idx(evict_addr(0))], evict_addr(0), WDATA_A);
  write_word(evict_addr(0), WDATA_A, lat);  // A allocated dirty
  for (int i = 1; i < 4; i++) begin
    read_word(evict_addr(i), got, lat);
  end
  n0 = req_log.size();
  read_word(evict_addr(4), got, lat);
  compare_value("lower request count", 128'(req_log.size() - n0), 128'(2));
  compare_value("lc_req.we", 128'(req_log[n0].we), 128'(1));
  compare_value("lc_req.addr", 128'(req_log[n0].addr), 128'(line_addr(evict_addr(0))));
  compare_value("lc_req.line", 128'(req_log[n0].line), 128'(exp_a));
  compare_value("lc_req.we", 128'(req_log[n0+1].we), 128'(0));
  compare_value("lc_req.addr", 128'(req_log[n0+1].addr), 128'(line_addr(evict_addr(4))));
  compare_value("hc_resp.rdata", 128'(got),
                128'(word_of(mem[line_idx(evict_addr(4))], evict_addr(4))));
endtask

task automatic resp_held_under_backpressure();
  int                      lat;
  logic [31:0]             addr;
  cache_bus_pkg::hc_resp_t first;
  addr          = evict_addr(1);  // B survived the eviction
  hc_resp_ready = 1'b0;
  send_req(addr, 1'b0, '0);
  wait_resp(lat, first);
  repeat (5) begin
    next_cycle();
    compare_value("hc_resp_valid", 128'(hc_resp_valid), 128'(1));
    compare_value("hc_resp", 128'(hc_resp), 128'(first));
  end
  hc_resp_ready = 1'b1;
  next_cycle();
  compare_value("hc_resp_valid", 128'(hc_resp_valid), 128'(0));
  compare_value("hc_resp.rdata", 128'(first.rdata), 128'(word_of(mem[line_idx(addr)], addr)));
endtask

task automatic flush_drops_lines();
  int                    n0;
  int                    r0;
  int                    w0;
  int                    lat;
  cache_geom_pkg::word_t got;
  wait_ready(lat);
  n0 = req_log.size();  // counted from before the flush
  r0 = rd_count;
  w0 = wr_count;
  flush = 1'b1;
  next_cycle();
  flush = 1'b0;
  compare_value("hc_req_ready", 128'(hc_req_ready), 128'(0));
  next_cycle();
  compare_value("hc_req_ready", 128'(hc_req_ready), 128'(1));
  read_word(ADDR_X, got, lat);
  compare_value("lower read count", 128'(rd_count - r0), 128'(1));
  compare_value("lower write count", 128'(wr_count - w0), 128'(0));  // dirty X dropped
  compare_value("lc_req.addr", 128'(req_log[n0].addr), 128'(line_addr(ADDR_X)));
  // memory still holds the preloaded word, the written one never left the cache
  compare_value("hc_resp.rdata", 128'(got), 128'(word_of(mem[line_idx(ADDR_X)], ADDR_X)));
endtask

`endif

/* testbench/tb_cache_top.sv */
// testbench for the set-associative write-back cache.
// drives the word side from the directed tasks in the included task file
// and answers the line side with a behavioral memory that adds ready delays
`timescale 1ns/1ps

module tb_cache_top;

  localparam int NUM_WAYS       = 4;
  localparam int NUM_SETS       = 16;
  localparam int MEM_IDX_W      = 8;    // 256 lines of backing memory
  localparam int MEM_LINES      = 1 << MEM_IDX_W;
  localparam int TIMEOUT_CYCLES = 200;

  logic                    clk_in;
  logic                    rst_N_in;
  logic                    flush;
  logic                    hc_req_valid, hc_req_ready;
  cache_bus_pkg::hc_req_t  hc_req;
  logic                    hc_resp_valid, hc_resp_ready;
  cache_bus_pkg::hc_resp_t hc_resp;
  logic                    lc_req_valid, lc_req_ready;
  cache_bus_pkg::lc_req_t  lc_req;
  logic                    lc_fill_valid, lc_fill_ready;
  cache_bus_pkg::lc_fill_t lc_fill;

  // lower memory model state
  cache_geom_pkg::line_t   mem [MEM_LINES];
  cache_bus_pkg::lc_req_t  req_log [$];     // every lower request, in order
  cache_bus_pkg::lc_req_t  req_snap;
  int                      rd_count;
  int                      wr_count;
  int                      seed;
  int                      ready_cnt;       // -1 while no request is being delayed
  logic                    req_xfer, fill_xfer, fill_due;
  logic [31:0]             fill_addr;

  cache_top #(.NUM_WAYS(NUM_WAYS), .NUM_SETS(NUM_SETS)) u_cache_top (.*);

  initial begin : clock_gen
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;  // 10 ns period
  end

  task automatic stop_failed(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  `include "tb_cache_tasks.svh"

  // line memory: ready after 0..3 cycles, fill one cycle after a read
  initial begin : lower_mem_model
    lc_req_ready  = 1'b0;
    lc_fill_valid = 1'b0;
    lc_fill       = '0;
    seed          = 32'h3dbfdda4;
    rd_count      = 0;
    wr_count      = 0;
    ready_cnt     = -1;
    req_xfer      = 1'b0;
    fill_xfer     = 1'b0;
    fill_due      = 1'b0;
    fill_addr     = '0;
    for (int i = 0; i < MEM_LINES; i++) begin
      mem[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    end
    forever begin
      @(posedge clk_in);
      #1;
      if (fill_xfer) lc_fill_valid = 1'b0;  // fill taken on the edge just passed
      if (fill_due) begin
        lc_fill_valid = 1'b1;
        lc_fill.addr  = fill_addr;
        lc_fill.line  = mem[line_idx(fill_addr)];
        fill_due      = 1'b0;
      end
      if (req_xfer) begin
        lc_req_ready = 1'b0;
        ready_cnt    = -1;
        req_log.push_back(req_snap);
        if (req_snap.we) begin
          mem[line_idx(req_snap.addr)] = req_snap.line;  // write-back lands here
          wr_count++;
        end else begin
          fill_due  = 1'b1;
          fill_addr = req_snap.addr;
          rd_count++;
        end
      end
      if (lc_req_valid && !lc_req_ready) begin
        if (ready_cnt < 0) ready_cnt = $unsigned($random(seed)) % 4;
        if (ready_cnt == 0) lc_req_ready = 1'b1;
        else ready_cnt--;
      end
      // what the coming edge will transfer, inputs and outputs are settled here
      req_xfer  = lc_req_valid && lc_req_ready;
      fill_xfer = lc_fill_valid && lc_fill_ready;
      req_snap  = lc_req;
    end
  end

  initial begin : test_sequence
    rst_N_in      = 1'b0;
    flush         = 1'b0;
    hc_req_valid  = 1'b0;
    hc_req        = '0;
    hc_resp_ready = 1'b1;
    repeat (16) @(posedge clk_in);
    #1;
    rst_N_in = 1'b1;
    // outputs straight out of reset
    compare_value("hc_req_ready", 128'(hc_req_ready), 128'(1));
    compare_value("hc_resp_valid", 128'(hc_resp_valid), 128'(0));
    compare_value("lc_req_valid", 128'(lc_req_valid), 128'(0));
    compare_value("lc_fill_ready", 128'(lc_fill_ready), 128'(0));
    read_miss_fills_line();
    read_hit_no_lower();
    write_hit_merges();
    dirty_victim_written_back();
    resp_held_under_backpressure();
    flush_drops_lines();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* cache_top.f */
+incdir+testbench
verilog/cache_geom_pkg.sv
verilog/cache_bus_pkg.sv
verilog/cache_way_ram.sv
verilog/cache_tag_store.sv
verilog/cache_plru.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
testbench/tb_cache_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it, then look for the pass line in the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --top-module tb_cache_top -f cache_top.f \
  --Mdir "$BUILD_DIR" -o tb_cache_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_cache_top" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi
